// ==== include/mini_core_defs.svh ====
// mini core build parameters
// data width, register count, reset pc and pipeline depth
`ifndef MINI_CORE_DEFS_SVH
`define MINI_CORE_DEFS_SVH

`define MC_XLEN       32      // register, pc and instruction word width
`define MC_NUM_REGS   8       // r0 always reads as zero
`define MC_RESET_PC   32'h0   // first word fetched after reset
`define MC_NUM_STAGES 4       // bit 0 is fetch and bit 3 is writeback in the masks

`endif

// ==== src/mini_core_pkg.sv ====
// mini core shared types
// opcodes, the two instruction word views and the stage-to-stage records
`include "mini_core_defs.svh"

package mini_core_pkg;

    typedef enum logic [3:0] {
        OP_NOP  = 4'h0,
        OP_ADD  = 4'h1,
        OP_SUB  = 4'h2,
        OP_AND  = 4'h3,
        OP_XOR  = 4'h4,
        OP_ADDI = 4'h5,
        OP_BEQ  = 4'h6
    } opcode_e;

    // the r view serves register ALU ops and BEQ, the i view serves ADDI
    typedef union packed {
        struct packed {
            opcode_e     opcode;  // [31:28] shared by both views
            logic [2:0]  rd;      // [27:25]
            logic [2:0]  rs1;     // [24:22]
            logic [2:0]  rs2;     // [21:19]
            logic [18:0] offset;  // signed branch offset in words
        } r;
        struct packed {
            opcode_e     opcode;
            logic [2:0]  rd;
            logic [2:0]  rs1;
            logic [21:0] imm;     // signed immediate for ADDI
        } i;
    } instr_u;

    typedef enum logic [1:0] {
        FWD_RF   = 2'd0,  // value read in decode
        FWD_WB   = 2'd1,  // result held by the writeback stage
        FWD_ZERO = 2'd2   // source is r0
    } fwd_sel_e;

    typedef struct packed {
        logic                valid;
        logic [`MC_XLEN-1:0] pc;
        opcode_e             opcode;
        logic [2:0]          rd;
        logic [2:0]          rs1;
        logic [2:0]          rs2;        // forced to r0 for ADDI
        logic [`MC_XLEN-1:0] rs1_val;
        logic [`MC_XLEN-1:0] rs2_val;
        logic [`MC_XLEN-1:0] imm;        // sign-extended immediate or offset
        logic                writes_rd;
    } dec_ex_t;

    typedef struct packed {
        logic                valid;
        logic [`MC_XLEN-1:0] pc;
        logic [`MC_XLEN-1:0] instr;      // word as it was fetched
        logic [2:0]          rd;
        logic                writes_rd;
        logic [`MC_XLEN-1:0] result;
    } ex_wb_t;

endpackage

// ==== src/mini_core_fwd_if.sv ====
// forwarding source interface
// one producing stage reports what it holds this cycle to the hazard block
`timescale 1ns/1ps
`include "mini_core_defs.svh"

interface mini_core_fwd_if;

    logic                valid;      // the stage holds a live instruction
    logic                writes_rd;  // that instruction updates rd
    logic [2:0]          rd;         // destination index
    logic [`MC_XLEN-1:0] result;     // value it will write

    modport producer (
        output valid,
        output writes_rd,
        output rd,
        output result
    );

    modport hazard (
        input valid,
        input writes_rd,
        input rd,
        input result
    );

endinterface

// ==== src/mini_core_hazard.sv ====
// mini core hazard and glue control
// forwarding selects, wrong-path flush, fetch bubbles and the pc load
`timescale 1ns/1ps
`include "mini_core_defs.svh"

module mini_core_hazard (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          ex_valid,
    input  logic [2:0]                    ex_rs1,
    input  logic [2:0]                    ex_rs2,
    input  logic                          branch_taken,
    input  logic [`MC_XLEN-1:0]           branch_target,
    input  logic                          fetch_empty,
    output mini_core_pkg::fwd_sel_e       fwd_sel_rs1,
    output mini_core_pkg::fwd_sel_e       fwd_sel_rs2,
    output logic [`MC_NUM_STAGES-1:0]     stage_flush,
    output logic [`MC_NUM_STAGES-1:0]     stage_stall,
    output logic                          pc_load_en,
    output logic [`MC_XLEN-1:0]           pc_load_val,
    mini_core_fwd_if.hazard               ex_fwd,
    mini_core_fwd_if.hazard               wb_fwd
);

    logic       wb_live;   // writeback holds a result that lands in the register file
    logic       redirect;  // a real taken branch sits in execute this cycle
    logic [1:0] drain_q;   // one bit per flushed slot still moving through execute

    function automatic mini_core_pkg::fwd_sel_e pick_src(input logic [2:0] rs,
                                                         input logic       live,
                                                         input logic [2:0] dst);
        mini_core_pkg::fwd_sel_e sel;
        if (rs == 3'd0) begin
            sel = mini_core_pkg::FWD_ZERO;          // r0 never takes a forwarded value
        end else if (live && dst == rs) begin
            sel = mini_core_pkg::FWD_WB;            // previous instruction wrote this source
        end else begin
            sel = mini_core_pkg::FWD_RF;            // decode's read already includes write-through
        end
        return sel;
    endfunction

    assign wb_live     = ex_valid & wb_fwd.valid & wb_fwd.writes_rd;
    assign fwd_sel_rs1 = pick_src(ex_rs1, wb_live, wb_fwd.rd);
    assign fwd_sel_rs2 = pick_src(ex_rs2, wb_live, wb_fwd.rd);

    // only a live non-writing op can redirect, and never from a slot already being drained
    assign redirect = branch_taken & ex_fwd.valid & ~ex_fwd.writes_rd & (drain_q == 2'b00);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            drain_q <= 2'b00;
        end else begin
            drain_q <= {drain_q[0], redirect};      // clears as the second bubble leaves execute
        end
    end

    always_comb begin
        stage_flush    = '0;
        stage_flush[0] = redirect;                  // wrong-path word being fetched
        stage_flush[1] = redirect;                  // wrong-path word in decode
        stage_stall    = '0;
        stage_stall[0] = fetch_empty;               // only fetch ever waits
    end

    assign pc_load_en  = redirect;
    assign pc_load_val = branch_target;

endmodule

// ==== src/mini_core_fetch.sv ====
// mini core fetch stage
// program counter, instruction port and the fetch-to-decode register
`timescale 1ns/1ps
`include "mini_core_defs.svh"

module mini_core_fetch (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`MC_XLEN-1:0]    imem_data,
    input  logic                   imem_valid,
    input  logic                   pc_load_en,
    input  logic [`MC_XLEN-1:0]    pc_load_val,
    input  logic                   flush,
    input  logic                   stall,
    output logic [`MC_XLEN-1:0]    imem_addr,
    output logic                   fetch_empty,
    output logic                   fd_valid,
    output logic [`MC_XLEN-1:0]    fd_pc,
    output mini_core_pkg::instr_u  fd_instr
);

    logic [`MC_XLEN-1:0] pc_q;  // word address of the instruction being fetched

    assign imem_addr   = pc_q;
    assign fetch_empty = ~imem_valid;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q     <= `MC_RESET_PC;
            fd_valid <= 1'b0;
        end else begin
            if (pc_load_en) begin
                pc_q <= pc_load_val;                // branch target wins over the increment
            end else if (!stall) begin
                pc_q <= pc_q + `MC_XLEN'(1);        // word addressed so one step per instruction
            end
            fd_valid <= ~flush & ~stall;            // wrong path or empty port becomes a bubble
        end
    end

    always_ff @(posedge clk) begin
        fd_pc    <= pc_q;
        fd_instr <= imem_data;
    end

endmodule

// ==== src/mini_core_decode.sv ====
// mini core decode stage
// field decode, register file with write-through and the decode-to-execute register
`timescale 1ns/1ps
`include "mini_core_defs.svh"

module mini_core_decode (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   fd_valid,
    input  logic [`MC_XLEN-1:0]    fd_pc,
    input  mini_core_pkg::instr_u  fd_instr,
    input  logic                   flush,
    input  logic                   wb_we,
    input  logic [2:0]             wb_rd,
    input  logic [`MC_XLEN-1:0]    wb_value,
    output mini_core_pkg::dec_ex_t de
);

    logic [`MC_XLEN-1:0]    rf [`MC_NUM_REGS];  // entry 0 is never written
    logic                   is_itype;           // ADDI takes the i view of the word
    mini_core_pkg::dec_ex_t de_d;

    // a write landing this cycle is seen by the read, so nothing two back is lost
    function automatic logic [`MC_XLEN-1:0] rf_read(input logic [2:0] idx);
        logic [`MC_XLEN-1:0] val;
        if (idx == 3'd0) begin
            val = '0;
        end else if (wb_we && wb_rd == idx) begin
            val = wb_value;
        end else begin
            val = rf[idx];
        end
        return val;
    endfunction

    always_ff @(posedge clk) begin
        if (wb_we && wb_rd != 3'd0) begin
            rf[wb_rd] <= wb_value;                  // writes to r0 are dropped here
        end
    end

    always_comb begin
        is_itype     = (fd_instr.i.opcode == mini_core_pkg::OP_ADDI);
        de_d.valid   = fd_valid & ~flush;
        de_d.pc      = fd_pc;
        de_d.opcode  = fd_instr.r.opcode;           // same bits in either view
        de_d.rd      = fd_instr.r.rd;
        de_d.rs1     = fd_instr.r.rs1;
        de_d.rs2     = is_itype ? 3'd0 : fd_instr.r.rs2;  // immediate bits are not a source
        de_d.rs1_val = rf_read(de_d.rs1);
        de_d.rs2_val = rf_read(de_d.rs2);
        if (is_itype) begin
            de_d.imm = {{(`MC_XLEN-22){fd_instr.i.imm[21]}}, fd_instr.i.imm};
        end else begin
            de_d.imm = {{(`MC_XLEN-19){fd_instr.r.offset[18]}}, fd_instr.r.offset};
        end
        case (fd_instr.r.opcode)
            mini_core_pkg::OP_ADD,
            mini_core_pkg::OP_SUB,
            mini_core_pkg::OP_AND,
            mini_core_pkg::OP_XOR,
            mini_core_pkg::OP_ADDI: de_d.writes_rd = 1'b1;
            default:                de_d.writes_rd = 1'b0;  // BEQ, NOP and unknown codes
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            de.valid <= 1'b0;
        end else begin
            de <= de_d;                             // a flush arrives here as valid low
        end
    end

endmodule

// ==== src/mini_core_execute.sv ====
// mini core execute stage
// operand forwarding, ALU, branch compare and the execute-to-writeback register
`timescale 1ns/1ps
`include "mini_core_defs.svh"

module mini_core_execute (
    input  logic                    clk,
    input  logic                    rst_n,
    input  mini_core_pkg::dec_ex_t  de,
    input  mini_core_pkg::fwd_sel_e fwd_sel_rs1,
    input  mini_core_pkg::fwd_sel_e fwd_sel_rs2,
    input  logic [`MC_XLEN-1:0]     wb_result,
    output logic                    ex_valid,
    output logic [2:0]              ex_rs1,
    output logic [2:0]              ex_rs2,
    output logic                    branch_taken,
    output logic [`MC_XLEN-1:0]     branch_target,
    output mini_core_pkg::ex_wb_t   ew,
    mini_core_fwd_if.producer       ex_fwd
);

    logic [`MC_XLEN-1:0]   op_a;    // first operand after forwarding
    logic [`MC_XLEN-1:0]   op_b;    // second operand after forwarding
    logic [`MC_XLEN-1:0]   result;
    mini_core_pkg::instr_u word;    // fetched word rebuilt for the retirement trace
    mini_core_pkg::ex_wb_t ew_d;

    function automatic logic [`MC_XLEN-1:0] operand(input mini_core_pkg::fwd_sel_e sel,
                                                    input logic [`MC_XLEN-1:0]     rf_val,
                                                    input logic [`MC_XLEN-1:0]     wb_val);
        logic [`MC_XLEN-1:0] val;
        case (sel)
            mini_core_pkg::FWD_WB:   val = wb_val;
            mini_core_pkg::FWD_ZERO: val = '0;
            default:                 val = rf_val;
        endcase
        return val;
    endfunction

    assign op_a = operand(fwd_sel_rs1, de.rs1_val, wb_result);
    assign op_b = operand(fwd_sel_rs2, de.rs2_val, wb_result);

    always_comb begin
        case (de.opcode)
            mini_core_pkg::OP_ADD:  result = op_a + op_b;     // all arithmetic wraps
            mini_core_pkg::OP_SUB:  result = op_a - op_b;
            mini_core_pkg::OP_AND:  result = op_a & op_b;
            mini_core_pkg::OP_XOR:  result = op_a ^ op_b;
            mini_core_pkg::OP_ADDI: result = op_a + de.imm;
            default:                result = '0;
        endcase
    end

    assign branch_taken  = de.valid && de.opcode == mini_core_pkg::OP_BEQ && op_a == op_b;
    assign branch_target = de.pc + de.imm;          // offset counts words from the branch

    // decode kept every field, so the original bits come back exactly
    always_comb begin
        word.r.opcode = de.opcode;
        word.r.rd     = de.rd;
        word.r.rs1    = de.rs1;
        if (de.opcode == mini_core_pkg::OP_ADDI) begin
            word.i.imm = de.imm[21:0];
        end else begin
            word.r.rs2    = de.rs2;
            word.r.offset = de.imm[18:0];
        end
    end

    always_comb begin
        ew_d.valid     = de.valid;
        ew_d.pc        = de.pc;
        ew_d.instr     = word;
        ew_d.rd        = de.rd;
        ew_d.writes_rd = de.writes_rd;
        ew_d.result    = result;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ew.valid <= 1'b0;
        end else begin
            ew <= ew_d;
        end
    end

    assign ex_valid         = de.valid;
    assign ex_rs1           = de.rs1;
    assign ex_rs2           = de.rs2;
    assign ex_fwd.valid     = de.valid;
    assign ex_fwd.writes_rd = de.writes_rd;
    assign ex_fwd.rd        = de.rd;
    assign ex_fwd.result    = result;

endmodule

// ==== src/mini_core_writeback.sv ====
// mini core writeback stage
// register file write port and the retirement trace one cycle behind it
`timescale 1ns/1ps
`include "mini_core_defs.svh"

module mini_core_writeback (
    input  logic                  clk,
    input  logic                  rst_n,
    input  mini_core_pkg::ex_wb_t ew,
    output logic                  wb_we,
    output logic [2:0]            wb_rd,
    output logic [`MC_XLEN-1:0]   wb_value,
    output logic                  retire_valid,
    output logic [`MC_XLEN-1:0]   retire_pc,
    output logic [`MC_XLEN-1:0]   retire_instr,
    output logic [2:0]            retire_rd,
    output logic                  retire_we,
    output logic [`MC_XLEN-1:0]   retire_value,
    mini_core_fwd_if.producer     wb_fwd
);

    assign wb_we    = ew.valid & ew.writes_rd;      // decode drops rd of zero on its own
    assign wb_rd    = ew.rd;
    assign wb_value = ew.result;

    assign wb_fwd.valid     = ew.valid;
    assign wb_fwd.writes_rd = ew.writes_rd;
    assign wb_fwd.rd        = ew.rd;
    assign wb_fwd.result    = ew.result;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= ew.valid;               // high one cycle per retired instruction
        end
    end

    always_ff @(posedge clk) begin
        retire_pc    <= ew.pc;
        retire_instr <= ew.instr;
        retire_rd    <= ew.rd;
        retire_we    <= ew.writes_rd;
        retire_value <= ew.result;                  // reported even when rd is r0
    end

endmodule

// ==== src/mini_core_top.sv ====
// mini core top level
// four-stage pipeline with its hazard block behind a plain instruction port
`timescale 1ns/1ps
`include "mini_core_defs.svh"

module mini_core_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [`MC_XLEN-1:0] imem_data,
    input  logic                imem_valid,
    output logic [`MC_XLEN-1:0] imem_addr,
    output logic                retire_valid,
    output logic [`MC_XLEN-1:0] retire_pc,
    output logic [`MC_XLEN-1:0] retire_instr,
    output logic [2:0]          retire_rd,
    output logic                retire_we,
    output logic [`MC_XLEN-1:0] retire_value
);

    logic                            fd_valid;
    logic [`MC_XLEN-1:0]             fd_pc;
    mini_core_pkg::instr_u           fd_instr;
    mini_core_pkg::dec_ex_t          de;
    mini_core_pkg::ex_wb_t           ew;
    mini_core_pkg::fwd_sel_e         fwd_sel_rs1;
    mini_core_pkg::fwd_sel_e         fwd_sel_rs2;
    logic [`MC_NUM_STAGES-1:0]       stage_flush;
    logic [`MC_NUM_STAGES-1:0]       stage_stall;
    logic                            pc_load_en;
    logic [`MC_XLEN-1:0]             pc_load_val;
    logic                            fetch_empty;
    logic                            ex_valid;
    logic [2:0]                      ex_rs1;
    logic [2:0]                      ex_rs2;
    logic                            branch_taken;
    logic [`MC_XLEN-1:0]             branch_target;
    logic                            wb_we;
    logic [2:0]                      wb_rd;
    logic [`MC_XLEN-1:0]             wb_value;

    mini_core_fwd_if ex_fwd_if ();  // what execute holds
    mini_core_fwd_if wb_fwd_if ();  // what writeback holds

    mini_core_fetch fetch0 (
        .clk, .rst_n, .imem_data, .imem_valid, .pc_load_en, .pc_load_val,
        .flush       (stage_flush[0]),
        .stall       (stage_stall[0]),
        .imem_addr, .fetch_empty, .fd_valid, .fd_pc, .fd_instr
    );

    mini_core_decode decode0 (
        .clk, .rst_n, .fd_valid, .fd_pc, .fd_instr,
        .flush       (stage_flush[1]),
        .wb_we, .wb_rd, .wb_value, .de
    );

    mini_core_execute execute0 (
        .clk, .rst_n, .de, .fwd_sel_rs1, .fwd_sel_rs2,
        .wb_result   (wb_value),
        .ex_valid, .ex_rs1, .ex_rs2, .branch_taken, .branch_target, .ew,
        .ex_fwd      (ex_fwd_if)
    );

    mini_core_writeback writeback0 (
        .clk, .rst_n, .ew, .wb_we, .wb_rd, .wb_value,
        .retire_valid, .retire_pc, .retire_instr, .retire_rd, .retire_we, .retire_value,
        .wb_fwd      (wb_fwd_if)
    );

    mini_core_hazard hazard0 (
        .clk, .rst_n, .ex_valid, .ex_rs1, .ex_rs2, .branch_taken, .branch_target,
        .fetch_empty, .fwd_sel_rs1, .fwd_sel_rs2, .stage_flush, .stage_stall,
        .pc_load_en, .pc_load_val,
        .ex_fwd      (ex_fwd_if),
        .wb_fwd      (wb_fwd_if)
    );

endmodule

// ==== verif/mini_core_properties.sv ====
// mini core retirement checker
// shadow architectural model with concurrent assertions on the retirement trace
`timescale 1ns/1ps
`include "mini_core_defs.svh"

module mini_core_properties (
    input logic                clk,
    input logic                rst_n,
    input logic [`MC_XLEN-1:0] imem_addr,
    input logic [`MC_XLEN-1:0] imem_data,
    input logic                imem_valid,
    input logic                retire_valid,
    input logic [`MC_XLEN-1:0] retire_pc,
    input logic [`MC_XLEN-1:0] retire_instr,
    input logic [2:0]          retire_rd,
    input logic                retire_we,
    input logic [`MC_XLEN-1:0] retire_value
);

    int                    fail_count = 0;            // read by the testbench at the end
    logic [`MC_XLEN-1:0]   shadow_rf [`MC_NUM_REGS];  // register state as seen at retirement
    logic [`MC_XLEN-1:0]   fetched_word [64];         // what the port delivered at each address
    logic [`MC_XLEN-1:0]   exp_instr;                 // word the port gave at the retired pc
    logic [`MC_XLEN-1:0]   exp_pc;                    // pc the next retirement has to carry
    logic                  fetched;                   // a word was accepted since reset
    mini_core_pkg::instr_u word;                      // retired word in both views
    logic [`MC_XLEN-1:0]   src_a;
    logic [`MC_XLEN-1:0]   src_b;
    logic [`MC_XLEN-1:0]   exp_value;                 // result the retired word must report
    logic [`MC_XLEN-1:0]   next_pc;
    logic                  writes;                    // the retired word updates rd

    always_comb begin
        word      = retire_instr;
        exp_instr = fetched_word[retire_pc[5:0]];
        src_a     = (word.r.rs1 == 3'd0) ? '0 : shadow_rf[word.r.rs1];  // r0 is always zero
        src_b     = (word.r.rs2 == 3'd0) ? '0 : shadow_rf[word.r.rs2];
        writes    = 1'b1;
        case (word.r.opcode)
            mini_core_pkg::OP_ADD:  exp_value = src_a + src_b;  // all arithmetic wraps
            mini_core_pkg::OP_SUB:  exp_value = src_a - src_b;
            mini_core_pkg::OP_AND:  exp_value = src_a & src_b;
            mini_core_pkg::OP_XOR:  exp_value = src_a ^ src_b;
            mini_core_pkg::OP_ADDI: exp_value = src_a + {{10{word.i.imm[21]}}, word.i.imm};
            default: begin
                exp_value = '0;
                writes    = 1'b0;                               // BEQ and NOP leave rd alone
            end
        endcase
        if (word.r.opcode == mini_core_pkg::OP_BEQ && src_a == src_b) begin
            next_pc = retire_pc + {{13{word.r.offset[18]}}, word.r.offset};  // taken
        end else begin
            next_pc = retire_pc + `MC_XLEN'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            exp_pc  <= `MC_RESET_PC;
            fetched <= 1'b0;
        end else begin
            if (imem_valid) begin
                fetched                      <= 1'b1;
                fetched_word[imem_addr[5:0]] <= imem_data;
            end
            if (retire_valid) begin
                exp_pc <= next_pc;
                if (writes && word.r.rd != 3'd0) begin
                    shadow_rf[word.r.rd] <= exp_value;          // the model drops r0 writes too
                end
            end
        end
    end

    reset_state: assert property (@(posedge clk)
        !rst_n |=> (imem_addr == `MC_RESET_PC && !retire_valid))
        else begin
            fail_count++;
            $error("reset did not leave imem_addr at the reset pc with retire_valid low");
        end

    idle_until_fetch: assert property (@(posedge clk) disable iff (!rst_n)
        !fetched |-> (imem_addr == `MC_RESET_PC && !retire_valid))
        else begin
            fail_count++;
            $error("core moved its pc or retired before any word was fetched");
        end

    value_match: assert property (@(posedge clk) disable iff (!rst_n)
        (retire_valid && writes) |-> retire_value == exp_value)
        else begin
            fail_count++;
            $error("ERROR t=%0t retire_value got %h expected %h",
                   $time, $sampled(retire_value), $sampled(exp_value));
        end

    pc_order: assert property (@(posedge clk) disable iff (!rst_n)
        retire_valid |-> retire_pc == exp_pc)
        else begin
            fail_count++;
            $error("ERROR t=%0t retire_pc got %h expected %h",
                   $time, $sampled(retire_pc), $sampled(exp_pc));
        end

    instr_match: assert property (@(posedge clk) disable iff (!rst_n)
        retire_valid |-> retire_instr == exp_instr)
        else begin
            fail_count++;
            $error("ERROR t=%0t retire_instr got %h expected %h",
                   $time, $sampled(retire_instr), $sampled(exp_instr));
        end

    rd_match: assert property (@(posedge clk) disable iff (!rst_n)
        retire_valid |-> retire_rd == word.r.rd)
        else begin
            fail_count++;
            $error("ERROR t=%0t retire_rd got %0d expected %0d",
                   $time, $sampled(retire_rd), $sampled(word.r.rd));
        end

    we_match: assert property (@(posedge clk) disable iff (!rst_n)
        retire_valid |-> retire_we == writes)
        else begin
            fail_count++;
            $error("ERROR t=%0t retire_we got %b expected %b",
                   $time, $sampled(retire_we), $sampled(writes));
        end

endmodule

// ==== verif/mini_core_tb.sv ====
// mini core testbench
// runs the test programs through the core while the bound checker watches retirement
`timescale 1ns/1ps
`include "mini_core_defs.svh"

module mini_core_tb;

    localparam int PROG_WORDS = 1 + 6 + 8 + 12 + 9;        // words over all five programs
    localparam int TEST_SLACK = 8 + 3 * `MC_NUM_STAGES;    // reset, idle port, fill and drain
    localparam int NUM_TESTS  = 5;

    logic                clk;
    logic                rst_n;
    logic [`MC_XLEN-1:0] imem_data;
    logic                imem_valid;
    logic [`MC_XLEN-1:0] imem_addr;
    logic                retire_valid;
    logic [`MC_XLEN-1:0] retire_pc;
    logic [`MC_XLEN-1:0] retire_instr;
    logic [2:0]          retire_rd;
    logic                retire_we;
    logic [`MC_XLEN-1:0] retire_value;
    logic [`MC_XLEN-1:0] imem [64];        // word-indexed instruction memory
    logic [`MC_XLEN-1:0] prog_q [$];       // program being built for the next test
    int                  prog_len;         // the port is empty past this address
    logic                port_open;        // registered port enable driven on the clock edge
    logic                port_enable;
    logic                gap_mode;         // follow the random gap pattern instead
    logic                gap_open [64];
    logic [5:0]          gap_idx;
    int                  retired;          // retirements since the last reset
    int                  limit_cycles;
    int                  failed_tests;
    string               cur_test;

    mini_core_top dut0 (
        .clk, .rst_n, .imem_data, .imem_valid, .imem_addr,
        .retire_valid, .retire_pc, .retire_instr, .retire_rd, .retire_we, .retire_value
    );

    bind mini_core_top mini_core_properties props0 (
        .clk, .rst_n, .imem_addr, .imem_data, .imem_valid,
        .retire_valid, .retire_pc, .retire_instr, .retire_rd, .retire_we, .retire_value
    );

    assign imem_data  = imem[imem_addr[5:0]];
    assign imem_valid = port_open && (imem_addr < prog_len);  // nothing beyond the program

    always #20 clk = ~clk;

    always @(posedge clk) begin
        if (gap_mode) begin
            port_open <= gap_open[gap_idx];
            gap_idx   <= gap_idx + 6'd1;
        end else begin
            port_open <= port_enable;
            gap_idx   <= '0;
        end
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            retired <= 0;
        end else if (retire_valid) begin
            retired <= retired + 1;
        end
    end

    function automatic logic [`MC_XLEN-1:0] encode_r(input mini_core_pkg::opcode_e op,
                                                     input int rd, input int rs1,
                                                     input int rs2, input int off);
        return {op, 3'(rd), 3'(rs1), 3'(rs2), 19'(off)};
    endfunction

    function automatic logic [`MC_XLEN-1:0] encode_i(input mini_core_pkg::opcode_e op,
                                                     input int rd, input int rs1,
                                                     input int imm);
        return {op, 3'(rd), 3'(rs1), 22'(imm)};
    endfunction

    task automatic load_program();
        int a;
        for (a = 0; a < 64; a++) begin
            imem[a] = {mini_core_pkg::OP_NOP, 28'(a)};  // harmless filler tagged by address
        end
        for (a = 0; a < prog_q.size(); a++) begin
            imem[a] = prog_q[a];
        end
        prog_len = prog_q.size();
    endtask

    // reset, load, release and wait until the expected number of words retired
    task automatic run_test(input string name, input int expect_count, input logic gaps,
                            input int idle_cycles);
        int fails_before;
        int fails_now;
        fails_before = dut0.props0.fail_count;
        cur_test     = name;
        @(posedge clk);
        rst_n       <= 1'b0;
        port_enable <= 1'b0;
        gap_mode    <= 1'b0;
        @(posedge clk);
        load_program();
        @(posedge clk);
        rst_n    <= 1'b1;
        gap_mode <= gaps;
        repeat (idle_cycles) @(posedge clk);
        port_enable <= 1'b1;
        while (retired < expect_count) @(posedge clk);
        repeat (`MC_NUM_STAGES) @(posedge clk);    // a stray wrong-path retirement lands here
        fails_now = dut0.props0.fail_count - fails_before;
        if (fails_now != 0) begin
            failed_tests++;
        end
        $display("test %s finished: %0d retired, %0d assertion failures",
                 name, retired, fails_now);
    endtask

    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("timeout: test %s did not finish within %0d cycles", cur_test, limit_cycles);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        int gaps;
        int i;
        clk          = 1'b0;
        rst_n        = 1'b0;
        port_open    = 1'b0;
        port_enable  = 1'b0;
        gap_mode     = 1'b0;
        gap_idx      = '0;
        prog_len     = 0;
        failed_tests = 0;
        limit_cycles = 0;
        cur_test     = "startup";
        void'($urandom(32'hdcb2));
        gaps = 0;
        for (i = 0; i < 64; i++) begin
            gap_open[i] = ($urandom % 4) != 0;          // roughly one empty cycle in four
            if (!gap_open[i]) begin
                gaps++;
            end
        end
        limit_cycles = PROG_WORDS + gaps + NUM_TESTS * TEST_SLACK + 20;

        prog_q.delete();
        prog_q.push_back(encode_i(mini_core_pkg::OP_ADDI, 1, 0, 7));
        run_test("after_reset", 1, 1'b0, `MC_NUM_STAGES);  // port stays empty a while

        prog_q.delete();
        prog_q.push_back(encode_i(mini_core_pkg::OP_ADDI, 1, 0, 5));       // r1 = 5
        prog_q.push_back(encode_r(mini_core_pkg::OP_ADD, 2, 1, 1, 0));     // r2 = 10
        prog_q.push_back(encode_r(mini_core_pkg::OP_SUB, 3, 2, 1, 0));     // r3 = 5
        prog_q.push_back(encode_r(mini_core_pkg::OP_AND, 4, 3, 2, 0));     // r4 = 0
        prog_q.push_back(encode_r(mini_core_pkg::OP_XOR, 5, 4, 3, 0));     // r5 = 5
        prog_q.push_back(encode_i(mini_core_pkg::OP_ADDI, 6, 5, -3));      // r6 = 2
        run_test("dependent_chain", 6, 1'b0, 0);

        prog_q.delete();
        prog_q.push_back(encode_i(mini_core_pkg::OP_ADDI, 1, 0, 4));
        prog_q.push_back(encode_i(mini_core_pkg::OP_ADDI, 2, 0, 4));
        prog_q.push_back(encode_r(mini_core_pkg::OP_BEQ, 0, 1, 2, 3));     // taken to 5
        prog_q.push_back(encode_i(mini_core_pkg::OP_ADDI, 3, 0, 1));       // wrong path
        prog_q.push_back(encode_i(mini_core_pkg::OP_ADDI, 3, 0, 2));       // wrong path
        prog_q.push_back(encode_r(mini_core_pkg::OP_BEQ, 0, 1, 0, 2));     // not taken
        prog_q.push_back(encode_r(mini_core_pkg::OP_XOR, 4, 1, 2, 0));     // r4 = 0
        prog_q.push_back(encode_i(mini_core_pkg::OP_ADDI, 5, 4, 9));       // r5 = 9
        run_test("branches", 6, 1'b0, 0);

        prog_q.delete();
        prog_q.push_back(encode_i(mini_core_pkg::OP_ADDI, 1, 0, 3));       // r1 = 3
        prog_q.push_back(encode_i(mini_core_pkg::OP_ADDI, 2, 1, 3));       // r2 = 6
        prog_q.push_back(encode_r(mini_core_pkg::OP_ADD, 3, 1, 2, 0));     // r3 = 9
        prog_q.push_back(encode_r(mini_core_pkg::OP_BEQ, 0, 3, 3, 2));     // taken to 5
        prog_q.push_back(encode_i(mini_core_pkg::OP_ADDI, 3, 0, 0));       // wrong path
        prog_q.push_back(encode_r(mini_core_pkg::OP_SUB, 4, 3, 1, 0));     // r4 = 6
        prog_q.push_back(encode_r(mini_core_pkg::OP_BEQ, 0, 4, 2, 2));     // taken to 8
        prog_q.push_back(encode_i(mini_core_pkg::OP_ADDI, 4, 0, 1));       // wrong path
        prog_q.push_back(encode_r(mini_core_pkg::OP_XOR, 5, 4, 3, 0));     // r5 = 15
        prog_q.push_back(encode_r(mini_core_pkg::OP_AND, 6, 5, 2, 0));     // r6 = 6
        prog_q.push_back(encode_r(mini_core_pkg::OP_BEQ, 0, 6, 1, 5));     // not taken
        prog_q.push_back(encode_i(mini_core_pkg::OP_ADDI, 7, 6, -1));      // r7 = 5
        run_test("random_gaps", 10, 1'b1, 0);

        prog_q.delete();
        prog_q.push_back(encode_i(mini_core_pkg::OP_ADDI, 0, 0, 5));       // reports 5, r0 stays 0
        prog_q.push_back(encode_r(mini_core_pkg::OP_ADD, 1, 0, 0, 0));     // r1 = 0
        prog_q.push_back(encode_i(mini_core_pkg::OP_ADDI, 2, 0, 7));       // r2 = 7
        prog_q.push_back(encode_r(mini_core_pkg::OP_ADD, 3, 0, 2, 0));     // r3 = 7
        prog_q.push_back(encode_r(mini_core_pkg::OP_ADD, 0, 2, 3, 0));     // reports 14
        prog_q.push_back(encode_r(mini_core_pkg::OP_SUB, 4, 2, 0, 0));     // r4 = 7
        prog_q.push_back(encode_r(mini_core_pkg::OP_BEQ, 0, 0, 1, 2));     // taken to 8
        prog_q.push_back(encode_i(mini_core_pkg::OP_ADDI, 5, 0, 1));       // wrong path
        prog_q.push_back(encode_i(mini_core_pkg::OP_ADDI, 5, 0, 2));       // r5 = 2
        run_test("r0_writes", 8, 1'b0, 0);

        $display("%0d tests run, %0d passed, %0d failed, %0d assertion failures",
                 NUM_TESTS, NUM_TESTS - failed_tests, failed_tests, dut0.props0.fail_count);
        if (failed_tests == 0 && dut0.props0.fail_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+include
src/mini_core_pkg.sv
src/mini_core_fwd_if.sv
src/mini_core_hazard.sv
src/mini_core_fetch.sv
src/mini_core_decode.sv
src/mini_core_execute.sv
src/mini_core_writeback.sv
src/mini_core_top.sv
verif/mini_core_properties.sv
verif/mini_core_tb.sv
